//--- source/psgPkg.sv
`default_nettype none

// ====================
// wave-table fetch path constants
// ====================

package psgPkg;

	// channel count and channel number width
	localparam int numChannels = 8;
	localparam int chanIdxWidth = 3;

	// system memory word address
	localparam int addrWidth = 16;

	// signed sample word as stored in memory
	localparam int sampleWidth = 16;

	// loop length, a length of 0 stands for 256 words
	localparam int lengthWidth = 8;

	// three guard bits hold the sum of eight full-scale samples
	localparam int mixWidth = sampleWidth + 3;

endpackage

`default_nettype wire

//--- source/psgChannelFetch.sv
`timescale 1ns/1ps
`default_nettype none

module psgChannelFetch (
	input wire clk,
	input wire rst,
	input wire enable,
	input wire [psgPkg::addrWidth-1:0] startAddr,
	input wire [psgPkg::lengthWidth-1:0] length,
	input wire slotFull,
	input wire grant,
	input wire wrote,
	output logic req,
	output logic [psgPkg::addrWidth-1:0] addr
);

	logic [psgPkg::lengthWidth-1:0] index;
	logic [psgPkg::lengthWidth-1:0] lastIndex;
	logic inFlight;

	// length of 0 wraps to 255 here, which gives the 256-word loop
	assign lastIndex = length - 1'b1;

	assign addr = startAddr + {{(psgPkg::addrWidth - psgPkg::lengthWidth){1'b0}}, index};

	// one outstanding fetch per channel, and only into an empty slot
	assign req = enable & ~slotFull & ~inFlight;

	always_ff @(posedge clk) begin
		if (rst) begin
			index <= '0;
			inFlight <= 1'b0;
		end else begin
			if (grant) begin
				inFlight <= 1'b1;
			end else if (wrote) begin
				inFlight <= 1'b0;
			end
			// >= also recovers if length shrinks below the current index
			if (wrote) begin
				if (index >= lastIndex) begin
					index <= '0;
				end else begin
					index <= index + 1'b1;
				end
			end
		end
	end

	// the arbiter may only hand the bus to a channel that is asking for it
	assert property (@(posedge clk) disable iff (rst) grant |-> req)
		else $error("grant without request");

endmodule

`default_nettype wire

//--- source/psgBusArb.sv
`timescale 1ns/1ps
`default_nettype none

module psgBusArb (
	input wire clk,
	input wire rst,
	input wire ce,
	input wire busy,
	input wire [psgPkg::numChannels-1:0] req,
	output logic [psgPkg::numChannels-1:0] sel,
	output logic [psgPkg::chanIdxWidth-1:0] seln,
	output logic start
);

	logic arbNow;
	logic [psgPkg::numChannels-1:0] winSel;
	logic [psgPkg::chanIdxWidth-1:0] winIdx;

	// the start cycle is still idle on the bus, so skip it as well
	assign arbNow = ce & ~busy & ~start;

	// lowest set bit, channel 0 has top priority
	assign winSel = req & (~req + 1'b1);

	always_comb begin
		winIdx = '0;
		for (int i = psgPkg::numChannels - 1; i >= 0; i--) begin
			if (req[i]) begin
				winIdx = i[psgPkg::chanIdxWidth-1:0];
			end
		end
	end

	// ====================
	// owner register
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (arbNow && (|req)) begin
				sel <= winSel;
				seln <= winIdx;
				start <= 1'b1;
			end
			// no request: last owner stays selected
		end
	end

	assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
		else $error("sel not one-hot");

	assert property (@(posedge clk) disable iff (rst) (busy || !ce) |=> $stable(sel))
		else $error("sel moved while bus busy or ce low");

	// the new owner must have been requesting when it won
	assert property (@(posedge clk) disable iff (rst) start |-> |($past(req) & sel))
		else $error("start for a channel that was not requesting");

endmodule

`default_nettype wire

//--- source/psgBusMaster.sv
`timescale 1ns/1ps
`default_nettype none

module psgBusMaster (
	input wire clk,
	input wire rst,
	input wire start,
	input wire [psgPkg::chanIdxWidth-1:0] seln,
	input wire [psgPkg::numChannels-1:0][psgPkg::addrWidth-1:0] chanAddr,
	output logic wbCyc,
	output logic wbStb,
	output logic [psgPkg::addrWidth-1:0] wbAdr,
	input wire [psgPkg::sampleWidth-1:0] wbDatIn,
	input wire wbAck,
	output logic busy,
	output logic wrValid,
	output logic [psgPkg::chanIdxWidth-1:0] wrChan,
	output logic [psgPkg::sampleWidth-1:0] wrData
);

	typedef enum logic {
		stIdle,
		stXfer
	} masterState;

	masterState state;
	logic [psgPkg::chanIdxWidth-1:0] chanReg;

	// ====================
	// transfer control
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			wbStb <= 1'b0;
		end else begin
			case (state)
				stIdle: begin
					if (start) begin
						state <= stXfer;
						wbStb <= 1'b1;
					end
				end
				stXfer: begin
					// classic cycle ends on ack, idle cycle follows
					if (wbAck) begin
						state <= stIdle;
						wbStb <= 1'b0;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// channel and address captured once per transfer
	always_ff @(posedge clk) begin
		if (state == stIdle && start) begin
			chanReg <= seln;
			wbAdr <= chanAddr[seln];
		end
	end

	assign wbCyc = (state == stXfer);
	assign busy = wbCyc;

	// read data goes straight to the buffer on the ack cycle
	assign wrValid = wbCyc & wbAck;
	assign wrChan = chanReg;
	assign wrData = wbDatIn;

	assert property (@(posedge clk) disable iff (rst) wbStb == wbCyc)
		else $error("wbStb differs from wbCyc");

	assert property (@(posedge clk) disable iff (rst) (wbCyc && !wbAck) |=> $stable(wbAdr))
		else $error("wbAdr changed during a wait state");

endmodule

`default_nettype wire

//--- source/psgSampleBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module psgSampleBuffer (
	input wire clk,
	input wire rst,
	input wire wrValid,
	input wire [psgPkg::chanIdxWidth-1:0] wrChan,
	input wire [psgPkg::sampleWidth-1:0] wrData,
	input wire [psgPkg::numChannels-1:0] pop,
	output logic [psgPkg::numChannels-1:0] full,
	output logic [psgPkg::numChannels-1:0][psgPkg::sampleWidth-1:0] samples
);

	logic [psgPkg::numChannels-1:0] wrHit;

	// one-hot slot select for the incoming word
	always_comb begin
		wrHit = '0;
		wrHit[wrChan] = wrValid;
	end

	// ====================
	// slot state
	// ====================

	// a write on the same edge as a pop keeps the slot full
	always_ff @(posedge clk) begin
		if (rst) begin
			full <= '0;
		end else begin
			full <= wrHit | (full & ~pop);
		end
	end

	always_ff @(posedge clk) begin
		if (wrValid) begin
			samples[wrChan] <= wrData;
		end
	end

	// channels stop requesting while full, so an overwrite means lost samples
	assert property (@(posedge clk) disable iff (rst)
		wrValid |-> !(full[wrChan] && !pop[wrChan]))
		else $error("write into a full slot");

endmodule

`default_nettype wire

//--- source/psgMixer.sv
`timescale 1ns/1ps
`default_nettype none

module psgMixer (
	input wire clk,
	input wire rst,
	input wire sampleTick,
	input wire [psgPkg::numChannels-1:0] full,
	input wire [psgPkg::numChannels-1:0][psgPkg::sampleWidth-1:0] samples,
	output logic [psgPkg::numChannels-1:0] pop,
	output logic signed [psgPkg::mixWidth-1:0] mixOut,
	output logic mixValid
);

	logic signed [psgPkg::mixWidth-1:0] sum;

	// ====================
	// adder
	// ====================

	// empty slots add nothing
	always_comb begin
		logic signed [psgPkg::mixWidth-1:0] ext;
		sum = '0;
		ext = '0;
		for (int i = 0; i < psgPkg::numChannels; i++) begin
			ext = signed'(samples[i]);
			if (full[i]) begin
				sum = sum + ext;
			end
		end
	end

	// every slot used on this tick is released
	assign pop = full & {psgPkg::numChannels{sampleTick}};

	always_ff @(posedge clk) begin
		if (rst) begin
			mixOut <= '0;
			mixValid <= 1'b0;
		end else begin
			mixValid <= sampleTick;
			if (sampleTick) begin
				mixOut <= sum;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/psgWaveFetch.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveFetch (
	input wire clk,
	input wire rst,
	input wire ce,
	input wire sampleTick,
	input wire [psgPkg::numChannels-1:0] chanEnable,
	input wire [psgPkg::numChannels-1:0][psgPkg::addrWidth-1:0] chanStart,
	input wire [psgPkg::numChannels-1:0][psgPkg::lengthWidth-1:0] chanLength,
	output logic wbCyc,
	output logic wbStb,
	output logic [psgPkg::addrWidth-1:0] wbAdr,
	input wire [psgPkg::sampleWidth-1:0] wbDatIn,
	input wire wbAck,
	output logic signed [psgPkg::mixWidth-1:0] mixOut,
	output logic mixValid
);

	logic [psgPkg::numChannels-1:0] req;
	logic [psgPkg::numChannels-1:0] sel;
	logic [psgPkg::chanIdxWidth-1:0] seln;
	logic start;
	logic busy;
	logic [psgPkg::numChannels-1:0][psgPkg::addrWidth-1:0] chanAddr;
	logic [psgPkg::numChannels-1:0] grant;
	logic [psgPkg::numChannels-1:0] wrote;
	logic wrValid;
	logic [psgPkg::chanIdxWidth-1:0] wrChan;
	logic [psgPkg::sampleWidth-1:0] wrData;
	logic [psgPkg::numChannels-1:0] full;
	logic [psgPkg::numChannels-1:0][psgPkg::sampleWidth-1:0] samples;
	logic [psgPkg::numChannels-1:0] pop;

	// sel holds the last owner, so only the start cycle counts as a grant
	assign grant = start ? sel : '0;

	always_comb begin
		wrote = '0;
		wrote[wrChan] = wrValid;
	end

	// ====================
	// channels
	// ====================

	for (genvar i = 0; i < psgPkg::numChannels; i++) begin : genChan
		psgChannelFetch chan (
			.clk(clk),
			.rst(rst),
			.enable(chanEnable[i]),
			.startAddr(chanStart[i]),
			.length(chanLength[i]),
			.slotFull(full[i]),
			.grant(grant[i]),
			.wrote(wrote[i]),
			.req(req[i]),
			.addr(chanAddr[i])
		);
	end

	// ====================
	// bus side
	// ====================

	psgBusArb arb (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.busy(busy),
		.req(req),
		.sel(sel),
		.seln(seln),
		.start(start)
	);

	psgBusMaster master (
		.clk(clk),
		.rst(rst),
		.start(start),
		.seln(seln),
		.chanAddr(chanAddr),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbAdr(wbAdr),
		.wbDatIn(wbDatIn),
		.wbAck(wbAck),
		.busy(busy),
		.wrValid(wrValid),
		.wrChan(wrChan),
		.wrData(wrData)
	);

	// sample store and mix
	psgSampleBuffer buffer (
		.clk(clk),
		.rst(rst),
		.wrValid(wrValid),
		.wrChan(wrChan),
		.wrData(wrData),
		.pop(pop),
		.full(full),
		.samples(samples)
	);

	psgMixer mixer (
		.clk(clk),
		.rst(rst),
		.sampleTick(sampleTick),
		.full(full),
		.samples(samples),
		.pop(pop),
		.mixOut(mixOut),
		.mixValid(mixValid)
	);

endmodule

`default_nettype wire

//--- verification/wbSampleMem.sv
`timescale 1ns/1ps
`default_nettype none

module wbSampleMem #(
	parameter logic [15:0] dataKey = 16'h5A00,
	parameter int maxWait = 3
) (
	input wire clk,
	input wire rst,
	input wire wbCyc,
	input wire wbStb,
	input wire [psgPkg::addrWidth-1:0] wbAdr,
	output logic [psgPkg::sampleWidth-1:0] wbDatOut,
	output logic wbAck
);

	logic pending;
	int waitLeft;

	// read data follows the address, the master holds it until ack
	assign wbDatOut = wbAdr ^ dataKey;

	// ====================
	// ack with random wait states
	// ====================

	always @(posedge clk) begin
		int draw;
		if (rst) begin
			wbAck <= 1'b0;
			pending <= 1'b0;
			waitLeft <= 0;
		end else begin
			wbAck <= 1'b0;
			if (wbCyc && wbStb && !wbAck) begin
				if (!pending) begin
					draw = int'($urandom % (maxWait + 1));
					if (draw == 0) begin
						wbAck <= 1'b1;
					end else begin
						pending <= 1'b1;
						waitLeft <= draw - 1;
					end
				end else if (waitLeft == 0) begin
					wbAck <= 1'b1;
					pending <= 1'b0;
				end else begin
					waitLeft <= waitLeft - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/psgWaveFetchTb.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveFetchTb;

	localparam logic [15:0] dataKey = 16'h5A00;
	localparam int tickGap = 80;
	localparam int busTimeout = 100;
	localparam int mixTimeout = 10;

	logic clk = 1'b0;
	logic rst;
	logic ce;
	logic sampleTick;
	logic [psgPkg::numChannels-1:0] chanEnable;
	logic [psgPkg::numChannels-1:0][psgPkg::addrWidth-1:0] chanStart;
	logic [psgPkg::numChannels-1:0][psgPkg::lengthWidth-1:0] chanLength;
	logic wbCyc;
	logic wbStb;
	logic [psgPkg::addrWidth-1:0] wbAdr;
	logic [psgPkg::sampleWidth-1:0] wbDat;
	logic wbAck;
	logic signed [psgPkg::mixWidth-1:0] mixOut;
	logic mixValid;

	always #4 clk = ~clk;

	psgWaveFetch uut (
		.clk(clk), .rst(rst), .ce(ce), .sampleTick(sampleTick),
		.chanEnable(chanEnable), .chanStart(chanStart), .chanLength(chanLength),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr), .wbDatIn(wbDat), .wbAck(wbAck),
		.mixOut(mixOut), .mixValid(mixValid)
	);

	wbSampleMem #(.dataKey(dataKey), .maxWait(3)) mem (
		.clk(clk), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb),
		.wbAdr(wbAdr), .wbDatOut(wbDat), .wbAck(wbAck)
	);

	// ====================
	// helpers
	// ====================

	task automatic failRun(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compareValue(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			failRun($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, want));
		end
	endtask

	function automatic logic signed [15:0] memWord(input logic [15:0] addr);
		return addr ^ dataKey;
	endfunction

	// expected mix for word k of every masked loop
	// a length of 0 means a 256-word loop
	function automatic int predictMix(input int k, input logic [7:0] mask);
		int total;
		int loopLen;
		logic [15:0] addr;
		total = 0;
		for (int c = 0; c < psgPkg::numChannels; c++) begin
			loopLen = (chanLength[c] == 0) ? 256 : int'(chanLength[c]);
			addr = chanStart[c] + 16'(k % loopLen);
			if (mask[c]) begin
				total += memWord(addr);
			end
		end
		return total;
	endfunction

	task automatic applyReset();
		@(negedge clk);
		rst = 1'b1;
		ce = 1'b0;
		sampleTick = 1'b0;
		chanEnable = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic idleFor(input int n, input bit busQuiet);
		repeat (n) begin
			@(negedge clk);
			if (busQuiet) begin
				compareValue("wbCyc", wbCyc, 0);
			end
		end
	endtask

	task automatic awaitBus(input logic level, input string what);
		int n;
		n = 0;
		while (wbCyc !== level && n < busTimeout) begin
			@(negedge clk);
			n++;
		end
		if (wbCyc !== level) begin
			failRun($sformatf("timed out waiting for %s", what));
		end
	endtask

	task automatic tickAndCompare(input int k, input logic [7:0] mask);
		int n;
		@(negedge clk);
		sampleTick = 1'b1;
		@(negedge clk);
		sampleTick = 1'b0;
		n = 0;
		while (!mixValid && n < mixTimeout) begin
			@(negedge clk);
			n++;
		end
		if (!mixValid) begin
			failRun("no mixValid pulse after a sample tick");
		end
		compareValue("mixOut", mixOut, predictMix(k, mask));
	endtask

	// ====================
	// tests
	// ====================

	task automatic resetQuiet();
		applyReset();
		ce = 1'b1;
		repeat (10) begin
			@(negedge clk);
			compareValue("wbCyc", wbCyc, 0);
			compareValue("wbStb", wbStb, 0);
			compareValue("mixValid", mixValid, 0);
			compareValue("mixOut", mixOut, 0);
		end
	endtask

	task automatic singleChannelWrap();
		applyReset();
		chanStart[3] = 16'h1000;
		chanLength[3] = 8'd3;
		chanEnable = 8'b0000_1000;
		ce = 1'b1;
		for (int k = 0; k < 7; k++) begin
			idleFor(tickGap, 1'b0);
			tickAndCompare(k, 8'b0000_1000);
		end
	endtask

	// regions spread so that half the channels read negative samples
	task automatic priorityOrder();
		applyReset();
		for (int c = 0; c < psgPkg::numChannels; c++) begin
			chanStart[c] = 16'(c * 16'h2010);
			chanLength[c] = (c == 7) ? 8'd0 : 8'(c + 1);
		end
		chanEnable = '1;
		idleFor(5, 1'b1);
		ce = 1'b1;
		for (int c = 0; c < psgPkg::numChannels; c++) begin
			awaitBus(1'b1, "a bus transfer to start");
			compareValue("wbStb", wbStb, 1);
			compareValue("wbAdr", wbAdr, chanStart[c]);
			awaitBus(1'b0, "a bus transfer to end");
		end
	endtask

	task automatic fullMix();
		for (int k = 0; k < 6; k++) begin
			idleFor(tickGap, 1'b0);
			tickAndCompare(k, 8'hFF);
		end
	endtask

	// picks up at word 6 of every loop after fullMix
	task automatic holdWhileCeLow();
		idleFor(tickGap, 1'b0);
		ce = 1'b0;
		tickAndCompare(6, 8'hFF);
		idleFor(tickGap, 1'b1);
		tickAndCompare(6, 8'h00);
		ce = 1'b1;
		idleFor(tickGap, 1'b0);
		tickAndCompare(7, 8'hFF);
	endtask

	initial begin
		void'($urandom(60));
		rst = 1'b1;
		ce = 1'b0;
		sampleTick = 1'b0;
		chanEnable = '0;
		chanStart = '0;
		chanLength = '0;
		resetQuiet();
		singleChannelWrap();
		priorityOrder();
		fullMix();
		holdWhileCeLow();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
source/psgPkg.sv
source/psgChannelFetch.sv
source/psgBusArb.sv
source/psgBusMaster.sv
source/psgSampleBuffer.sv
source/psgMixer.sv
source/psgWaveFetch.sv
verification/wbSampleMem.sv
verification/psgWaveFetchTb.sv

//--- run.sh
#!/bin/bash
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module psgWaveFetchTb -f all.f

./obj_dir/VpsgWaveFetchTb 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
